// File: filelist.f
+incdir+.
rv_ctrl_pkg.sv
x_stage_ctrl.sv
x_wf_reg.sv
wf_stage_ctrl.sv
rv_ctrl_top.sv
tb_rv_ctrl.sv

// File: tb_rv_ctrl_ref.svh
/*
  Testbench helpers: Galois LFSR and random bit draws, instruction
  builder, and reference models of the X and WF control outputs
*/
`ifndef TB_RV_CTRL_REF_SVH
`define TB_RV_CTRL_REF_SVH

// Right-shifting Galois form, taps 32 30 26 25
function automatic logic [31:0] lfsr_step(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
endfunction

// One LFSR step per bit drawn
task automatic take_bits(input int n, output logic [31:0] v);
  v = '0;
  for (int k = 0; k < n; k++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_step(lfsr_state);
  end
endtask

function automatic inst_t build_inst(opc5_t opc, funct3_t f3, logic b30,
                                     reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
  return {1'b0, b30, 5'b0, rs2, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic opc5_t opcode_for_class(int c);
  case (c)
    0:       return OPC_RTYPE;
    1:       return OPC_ITYPE;
    2:       return OPC_LOAD;
    3:       return OPC_STORE;
    4:       return OPC_BRANCH;
    5:       return OPC_JAL;
    6:       return OPC_JALR;
    7:       return OPC_AUIPC;
    8:       return OPC_LUI;
    default: return 5'b11100;  // SYSTEM, decodes as no-op
  endcase
endfunction

function automatic alu_sel_t alu_for_funct3(logic [2:0] f, logic b30, logic is_r);
  case (f)
    3'd0:    return (is_r && b30) ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return b30 ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

// Packed as {alu_sel, a_sel, b_sel, br_un, br_taken, pc_sel}
function automatic logic [9:0] ref_x(inst_t i, logic v, logic eq, logic lt);
  logic [4:0] op;
  logic [2:0] f;
  alu_sel_t   alu;
  logic       a;
  logic       b;
  logic       un;
  logic       tk;
  pc_sel_t    pc;
  op = i[6:2];
  f  = i[14:12];
  alu = ALU_ADD;
  a = 1'b0;
  b = 1'b0;
  un = 1'b0;
  tk = 1'b0;
  pc = PC_PLUS4;
  if (v) begin
    if (op == OPC_RTYPE || op == OPC_ITYPE) begin
      alu = alu_for_funct3(f, i[30], op == OPC_RTYPE);
    end
    a = (op == OPC_BRANCH) || (op == OPC_JAL) || (op == OPC_AUIPC);
    b = (op == OPC_ITYPE) || (op == OPC_LOAD) || (op == OPC_STORE) ||
        (op == OPC_BRANCH) || (op == OPC_JAL) || (op == OPC_AUIPC) || (op == OPC_LUI);
    if (op == OPC_BRANCH) begin
      un = (f == 3'b110) || (f == 3'b111);
      case (f)
        3'b000:         tk = eq;
        3'b001:         tk = !eq;
        3'b100, 3'b110: tk = lt;
        3'b101, 3'b111: tk = !lt;
        default:        tk = 1'b0;
      endcase
    end
    if (tk || op == OPC_JAL || op == OPC_JALR) begin
      pc = PC_ALU;
    end
  end
  return {alu, a, b, un, tk, pc};
endfunction

// Packed as {rf_we, wb_sel, ldx_sel, fwd_a, fwd_b}
function automatic logic [7:0] ref_wf(inst_t wi, logic wv, inst_t xi, logic xv);
  logic [4:0] wop;
  logic [4:0] xop;
  logic [4:0] rd;
  logic       we;
  logic       reads1;
  logic       reads2;
  logic       fa;
  logic       fb;
  wb_sel_t    wb;
  ldx_sel_t   ldx;
  wop = wi[6:2];
  xop = xi[6:2];
  rd  = wi[11:7];
  wb  = WB_ALU;
  ldx = LDX_W;
  we = wv && ((wop == OPC_RTYPE) || (wop == OPC_ITYPE) || (wop == OPC_LOAD) ||
              (wop == OPC_JAL) || (wop == OPC_JALR) || (wop == OPC_AUIPC) ||
              (wop == OPC_LUI));
  if (wop == OPC_JAL || wop == OPC_JALR) begin
    wb = WB_PC4;
  end else if (wop == OPC_LOAD) begin
    wb = WB_MEM;
    case (wi[14:12])
      3'b000:  ldx = LDX_B;
      3'b001:  ldx = LDX_H;
      3'b100:  ldx = LDX_BU;
      3'b101:  ldx = LDX_HU;
      default: ldx = LDX_W;
    endcase
  end
  reads1 = !((xop == OPC_JAL) || (xop == OPC_AUIPC) || (xop == OPC_LUI));
  reads2 = (xop == OPC_RTYPE) || (xop == OPC_STORE) || (xop == OPC_BRANCH);
  fa = we && (rd != 5'd0) && xv && reads1 && (rd == xi[19:15]);
  fb = we && (rd != 5'd0) && xv && reads2 && (rd == xi[24:20]);
  return {we, wb, ldx, fa, fb};
endfunction

`endif

// File: tb_rv_ctrl.sv
/*
  Testbench for the X/WF control path: clock and reset, directed branch
  and load sweeps, random instruction stream, output comparison, watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ctrl import rv_ctrl_pkg::*;;

  localparam int RST_CYCLES = 4;
  localparam int NUM_INST   = 400;
  localparam int NUM_DIRECT = 40;   // 32 branch cases and 8 load widths
  localparam int CLK_PERIOD = 4;

  logic     clk = 1'b0;
  logic     rst;
  inst_t    inst;
  logic     inst_valid;
  logic     br_eq;
  logic     br_lt;
  alu_sel_t alu_sel;
  logic     a_sel;
  logic     b_sel;
  logic     br_un;
  logic     br_taken;
  pc_sel_t  pc_sel;
  logic     rf_we;
  wb_sel_t  wb_sel;
  ldx_sel_t ldx_sel;
  logic     fwd_a;
  logic     fwd_b;

  logic [31:0] lfsr_state = 32'hcd3a_e0a7;
  inst_t       prev_inst;    // Model of the instruction now in WF
  logic        prev_valid;

  `include "tb_rv_ctrl_ref.svh"

  rv_ctrl_top DUT (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .br_eq      (br_eq),
    .br_lt      (br_lt),
    .alu_sel    (alu_sel),
    .a_sel      (a_sel),
    .b_sel      (b_sel),
    .br_un      (br_un),
    .br_taken   (br_taken),
    .pc_sel     (pc_sel),
    .rf_we      (rf_we),
    .wb_sel     (wb_sel),
    .ldx_sel    (ldx_sel),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic drive_random();
    logic [31:0] cls;
    logic [31:0] f3;
    logic [31:0] b30;
    logic [31:0] regs;
    logic [31:0] vld;
    logic [31:0] flags;
    take_bits(4, cls);
    take_bits(3, f3);
    take_bits(1, b30);
    take_bits(6, regs);   // Indices 0 to 3 so hazards are common
    take_bits(3, vld);
    take_bits(2, flags);
    inst = build_inst(opcode_for_class(cls % 10), f3[2:0], b30[0],
                      regs[5:4], regs[3:2], regs[1:0]);
    inst_valid = (vld[2:0] != 3'd0);  // Bubble about one in eight
    br_eq = flags[1];
    br_lt = flags[0];
  endtask

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // WF reference register
  always @(posedge clk) begin
    if (rst) begin
      prev_valid <= 1'b0;
    end else begin
      prev_valid <= inst_valid;
    end
    prev_inst <= inst;
  end

  initial begin
    logic [31:0] regs;
    inst       = '0;
    inst_valid = 1'b0;
    br_eq      = 1'b0;
    br_lt      = 1'b0;
    rst        = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    // Every branch funct3 under all four flag pairs
    for (int f = 0; f < 8; f++) begin
      for (int fl = 0; fl < 4; fl++) begin
        take_bits(6, regs);
        inst = build_inst(OPC_BRANCH, f[2:0], 1'b0, regs[5:4], regs[3:2], regs[1:0]);
        inst_valid = 1'b1;
        {br_eq, br_lt} = fl[1:0];
        @(negedge clk);
      end
    end
    for (int f = 0; f < 8; f++) begin
      take_bits(6, regs);
      inst = build_inst(OPC_LOAD, f[2:0], 1'b0, regs[5:4], regs[3:2], regs[1:0]);
      inst_valid = 1'b1;
      @(negedge clk);
    end
    for (int n = 0; n < NUM_INST - NUM_DIRECT; n++) begin
      drive_random();
      @(negedge clk);
    end
    inst_valid = 1'b0;  // Drain the last instruction through WF
    @(negedge clk);
    #2;
    $display("No errors");
    $finish;
  end

  // Sample 1 ns before each rising edge
  initial begin
    logic [9:0] exp_x;
    logic [7:0] exp_wf;
    forever begin
      @(negedge clk);
      #1;
      exp_x  = ref_x(inst, inst_valid, br_eq, br_lt);
      exp_wf = ref_wf(prev_inst, prev_valid, inst, inst_valid);
      check_value("alu_sel", alu_sel, exp_x[9:6]);
      check_value("a_sel", a_sel, exp_x[5]);
      check_value("b_sel", b_sel, exp_x[4]);
      check_value("br_un", br_un, exp_x[3]);
      check_value("br_taken", br_taken, exp_x[2]);
      check_value("pc_sel", pc_sel, exp_x[1:0]);
      check_value("rf_we", rf_we, exp_wf[7]);
      if (exp_wf[7]) begin
        check_value("wb_sel", wb_sel, exp_wf[6:5]);  // Only defined for writers
      end
      if (prev_valid) begin
        check_value("ldx_sel", ldx_sel, exp_wf[4:2]);
      end
      check_value("fwd_a", fwd_a, exp_wf[1]);
      check_value("fwd_b", fwd_b, exp_wf[0]);
    end
  end

  initial begin
    #((RST_CYCLES + NUM_INST + 10) * CLK_PERIOD);
    $display("Watchdog expired before the stimulus finished");
    $display("Errors found");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

// File: rv_ctrl_top.sv
/*
  Top level of the two-stage control path: X decode,
  X to WF register and WF decode with forwarding
*/
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_top import rv_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  inst_t    inst,
  input  logic     inst_valid,
  input  logic     br_eq,
  input  logic     br_lt,
  output alu_sel_t alu_sel,
  output logic     a_sel,
  output logic     b_sel,
  output logic     br_un,
  output logic     br_taken,
  output pc_sel_t  pc_sel,
  output logic     rf_we,
  output wb_sel_t  wb_sel,
  output ldx_sel_t ldx_sel,
  output logic     fwd_a,
  output logic     fwd_b
);

  inst_t wf_inst;   // Instruction one cycle behind X
  logic  wf_valid;

  x_stage_ctrl u_x_ctrl (
    .inst       (inst),
    .inst_valid (inst_valid),
    .br_eq      (br_eq),
    .br_lt      (br_lt),
    .alu_sel    (alu_sel),
    .a_sel      (a_sel),
    .b_sel      (b_sel),
    .br_un      (br_un),
    .br_taken   (br_taken),
    .pc_sel     (pc_sel)
  );

  x_wf_reg u_x_wf_reg (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .wf_inst    (wf_inst),
    .wf_valid   (wf_valid)
  );

  wf_stage_ctrl u_wf_ctrl (
    .wf_inst  (wf_inst),
    .wf_valid (wf_valid),
    .x_inst   (inst),
    .x_valid  (inst_valid),
    .rf_we    (rf_we),
    .wb_sel   (wb_sel),
    .ldx_sel  (ldx_sel),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b)
  );

endmodule

`default_nettype wire

// File: wf_stage_ctrl.sv
/*
  Writeback-stage control: register-file write enable, writeback source,
  load extension, and forwarding of the WF result into the X operands
*/
`timescale 1ns/1ps
`default_nettype none

module wf_stage_ctrl import rv_ctrl_pkg::*; (
  input  inst_t    wf_inst,
  input  logic     wf_valid,
  input  inst_t    x_inst,
  input  logic     x_valid,
  output logic     rf_we,
  output wb_sel_t  wb_sel,
  output ldx_sel_t ldx_sel,
  output logic     fwd_a,
  output logic     fwd_b
);

  opc5_t    wf_opc;
  opc5_t    x_opc;
  reg_idx_t wf_rd;
  logic     writes_rd;  // WF opcode produces a register result
  logic     x_uses_rs1;
  logic     x_uses_rs2;

  assign wf_opc = get_opc(wf_inst);
  assign x_opc  = get_opc(x_inst);
  assign wf_rd  = get_rd(wf_inst);

  always_comb begin
    writes_rd = 1'b0;
    wb_sel    = WB_MEM;
    ldx_sel   = LDX_W;
    case (wf_opc)
      OPC_RTYPE, OPC_ITYPE, OPC_AUIPC, OPC_LUI: begin
        writes_rd = 1'b1;
        wb_sel    = WB_ALU;
      end
      OPC_LOAD: begin
        writes_rd = 1'b1;
        case (get_funct3(wf_inst))
          F3_LB:   ldx_sel = LDX_B;
          F3_LH:   ldx_sel = LDX_H;
          F3_LBU:  ldx_sel = LDX_BU;
          F3_LHU:  ldx_sel = LDX_HU;
          default: ldx_sel = LDX_W;  // LW and reserved widths
        endcase
      end
      OPC_JAL, OPC_JALR: begin
        writes_rd = 1'b1;
        wb_sel    = WB_PC4;  // Link register gets PC + 4
      end
      default: begin
        writes_rd = 1'b0;
      end
    endcase
  end

  assign rf_we = wf_valid && writes_rd;

  // Operand usage of the instruction now in X
  assign x_uses_rs1 = !(x_opc == OPC_JAL || x_opc == OPC_AUIPC || x_opc == OPC_LUI);
  assign x_uses_rs2 = (x_opc == OPC_RTYPE) || (x_opc == OPC_STORE) ||
                      (x_opc == OPC_BRANCH);

  // x0 is never forwarded
  assign fwd_a = rf_we && (wf_rd != '0) && x_valid && x_uses_rs1 &&
                 (wf_rd == get_rs1(x_inst));
  assign fwd_b = rf_we && (wf_rd != '0) && x_valid && x_uses_rs2 &&
                 (wf_rd == get_rs2(x_inst));

endmodule

`default_nettype wire

// File: x_wf_reg.sv
/*
  X to WF pipeline register for the instruction word and valid bit
*/
`timescale 1ns/1ps
`default_nettype none

module x_wf_reg import rv_ctrl_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  inst_t inst,
  input  logic  inst_valid,
  output inst_t wf_inst,
  output logic  wf_valid
);

  always_ff @(posedge clk) begin
    if (rst) begin
      wf_valid <= 1'b0;
    end else begin
      wf_valid <= inst_valid;  // Low input leaves a bubble in WF
    end
  end

  always_ff @(posedge clk) begin
    wf_inst <= inst;
  end

endmodule

`default_nettype wire

// File: x_stage_ctrl.sv
/*
  Execute-stage control decode: ALU operation, operand selects,
  unsigned compare, branch resolution and next-PC select
*/
`timescale 1ns/1ps
`default_nettype none

module x_stage_ctrl import rv_ctrl_pkg::*; (
  input  inst_t    inst,
  input  logic     inst_valid,
  input  logic     br_eq,
  input  logic     br_lt,
  output alu_sel_t alu_sel,
  output logic     a_sel,
  output logic     b_sel,
  output logic     br_un,
  output logic     br_taken,
  output pc_sel_t  pc_sel
);

  opc5_t    opc;
  funct3_t  f3;
  alu_sel_t alu_arith;  // ALU op for R and I formats
  logic     br_cond;    // Branch condition from comparator flags

  assign opc = get_opc(inst);
  assign f3  = get_funct3(inst);

  // Bit 30 picks SUB only for R-type, SRA for both formats
  always_comb begin
    case (f3)
      F3_ADD_SUB: alu_arith = (opc == OPC_RTYPE && inst[30]) ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_arith = ALU_SLL;
      F3_SLT:     alu_arith = ALU_SLT;
      F3_SLTU:    alu_arith = ALU_SLTU;
      F3_XOR:     alu_arith = ALU_XOR;
      F3_SRL_SRA: alu_arith = inst[30] ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_arith = ALU_OR;
      default:    alu_arith = ALU_AND;
    endcase
  end

  always_comb begin
    case (f3)
      F3_BEQ:  br_cond = br_eq;
      F3_BNE:  br_cond = !br_eq;
      F3_BLT,
      F3_BLTU: br_cond = br_lt;   // Signedness set by br_un
      F3_BGE,
      F3_BGEU: br_cond = !br_lt;
      default: br_cond = 1'b0;    // Reserved encodings never branch
    endcase
  end

  always_comb begin
    alu_sel  = ALU_ADD;  // Address and link arithmetic by default
    a_sel    = 1'b0;
    b_sel    = 1'b0;
    br_un    = 1'b0;
    br_taken = 1'b0;
    pc_sel   = PC_PLUS4;
    if (inst_valid) begin
      case (opc)
        OPC_RTYPE: begin
          alu_sel = alu_arith;
        end
        OPC_ITYPE: begin
          alu_sel = alu_arith;
          b_sel   = 1'b1;
        end
        OPC_LOAD, OPC_STORE, OPC_LUI: begin
          b_sel = 1'b1;  // rs1 + imm, or imm alone
        end
        OPC_BRANCH: begin
          a_sel    = 1'b1;  // PC + offset
          b_sel    = 1'b1;
          br_un    = (f3 == F3_BLTU) || (f3 == F3_BGEU);
          br_taken = br_cond;
          pc_sel   = br_cond ? PC_ALU : PC_PLUS4;
        end
        OPC_JAL: begin
          a_sel  = 1'b1;
          b_sel  = 1'b1;
          pc_sel = PC_ALU;
        end
        OPC_JALR: begin
          pc_sel = PC_ALU;
        end
        OPC_AUIPC: begin
          a_sel = 1'b1;
          b_sel = 1'b1;
        end
        default: begin
          // CSR and unknown opcodes behave as a no-op
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rv_ctrl_pkg.sv
/*
  Shared definitions for the X/WF pipeline control path:
  vector typedefs, RV32I opcode and funct3 codes, select encodings
  and instruction field extraction helpers
*/
`default_nettype none

package rv_ctrl_pkg;

  typedef logic [31:0] inst_t;     // One instruction word
  typedef logic [4:0]  opc5_t;     // Opcode bits 6:2
  typedef logic [2:0]  funct3_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  alu_sel_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic [2:0]  ldx_sel_t;
  typedef logic [1:0]  pc_sel_t;

  // Major opcodes, low two bits dropped
  localparam opc5_t OPC_RTYPE  = 5'b01100;
  localparam opc5_t OPC_ITYPE  = 5'b00100;
  localparam opc5_t OPC_LOAD   = 5'b00000;
  localparam opc5_t OPC_STORE  = 5'b01000;
  localparam opc5_t OPC_BRANCH = 5'b11000;
  localparam opc5_t OPC_JAL    = 5'b11011;
  localparam opc5_t OPC_JALR   = 5'b11001;
  localparam opc5_t OPC_AUIPC  = 5'b00101;
  localparam opc5_t OPC_LUI    = 5'b01101;

  // Arithmetic funct3
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // Branch funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Load funct3
  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;

  localparam alu_sel_t ALU_ADD  = 4'd0;
  localparam alu_sel_t ALU_SUB  = 4'd1;
  localparam alu_sel_t ALU_AND  = 4'd2;
  localparam alu_sel_t ALU_OR   = 4'd3;
  localparam alu_sel_t ALU_XOR  = 4'd4;
  localparam alu_sel_t ALU_SLL  = 4'd5;
  localparam alu_sel_t ALU_SRL  = 4'd6;
  localparam alu_sel_t ALU_SRA  = 4'd7;
  localparam alu_sel_t ALU_SLT  = 4'd8;
  localparam alu_sel_t ALU_SLTU = 4'd9;

  localparam wb_sel_t WB_MEM = 2'd0;
  localparam wb_sel_t WB_ALU = 2'd1;
  localparam wb_sel_t WB_PC4 = 2'd2;  // Link address for jumps

  localparam ldx_sel_t LDX_W  = 3'd0;
  localparam ldx_sel_t LDX_HU = 3'd1;
  localparam ldx_sel_t LDX_H  = 3'd2;
  localparam ldx_sel_t LDX_BU = 3'd3;
  localparam ldx_sel_t LDX_B  = 3'd4;

  localparam pc_sel_t PC_PLUS4 = 2'd2;
  localparam pc_sel_t PC_ALU   = 2'd3;  // Branch or jump target from ALU

  // Field extraction
  function automatic opc5_t get_opc(inst_t i);
    return i[6:2];
  endfunction

  function automatic funct3_t get_funct3(inst_t i);
    return i[14:12];
  endfunction

  function automatic reg_idx_t get_rd(inst_t i);
    return i[11:7];
  endfunction

  function automatic reg_idx_t get_rs1(inst_t i);
    return i[19:15];
  endfunction

  function automatic reg_idx_t get_rs2(inst_t i);
    return i[24:20];
  endfunction

endpackage

`default_nettype wire
